//--- project.f
+incdir+include
hw/dft_types_pkg.sv
hw/dft_ctrl_pkg.sv
hw/dft_sample_ram.sv
hw/dft_sequencer.sv
hw/dft_butterfly.sv
hw/dft_writeback.sv
hw/dft_source.sv
hw/dft_mem_top.sv
testbench/tb_dft_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DFT memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f --top-module tb_dft_mem_top -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- testbench/tb_dft_mem_top.sv
// Table-driven testbench for the DFT memory controller
// Expected spectra come from a direct DFT with twiddles of +-1 and +-j
// Samples stay within +-1000, so no result wraps at the sample width
// Inputs change on the rising edge and outputs are sampled on the falling edge

`default_nettype none
`timescale 1ns/1ps

`include "dft_defines.svh"

module tb_dft_mem_top
	import dft_types_pkg::*;
	import dft_ctrl_pkg::*;
();

	// One table row holds size, gap and timeout flags and a sample set
	typedef struct packed {
		log2_pts_t  size;
		logic       gap;
		logic       tmo;
		logic [2:0] idx;
	} test_entry_t;

	localparam int NUM_TESTS = 8;
	localparam int NUM_SETS  = 6;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	logic       in_sop;
	log2_pts_t  in_size;
	cplx_t      in_data;
	logic       sink_ready;
	mem_state_t state;
	logic       out_valid;
	logic       out_sop;
	logic       out_eop;
	cplx_t      out_data;

	test_entry_t tests [NUM_TESTS];
	cplx_t       pool [NUM_SETS*4];
	int          exp_re [4];
	int          exp_im [4];
	int          err_value;
	int          err_other;
	int          frames_seen;
	int          accepted;
	int          cycle_cnt;
	int          cycle_limit;
	logic        pkt_started;
	logic [31:0] lcg_state;

	dft_mem_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_sop     (in_sop),
		.in_size    (in_size),
		.in_data    (in_data),
		.sink_ready (sink_ready),
		.state      (state),
		.out_valid  (out_valid),
		.out_sop    (out_sop),
		.out_eop    (out_eop),
		.out_data   (out_data)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Upper half of the LCG state folded into -1000..1000
	function automatic sample_t lcg_sample(input logic [31:0] s);
		int v;
		v = int'({16'd0, s[31:16]}) % 2001 - 1000;
		return sample_t'(v);
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		err_value++;
	endtask

	// Direct N-point DFT of one sample set in natural order
	task automatic compute_expected(input int set, input int n);
		int q;
		int re;
		int im;
		int tmp;
		int acc_re;
		int acc_im;
		for (int k = 0; k < n; k++) begin
			acc_re = 0;
			acc_im = 0;
			for (int m = 0; m < n; m++) begin
				re = int'(pool[set*4+m].re);
				im = int'(pool[set*4+m].im);
				// W_N^(mk) counted in quarter turns of -j
				q = (m * k * (4 / n)) % 4;
				repeat (q) begin
					tmp = re;
					re  = im;
					im  = -tmp;
				end
				acc_re += re;
				acc_im += im;
			end
			exp_re[k] = acc_re;
			exp_im[k] = acc_im;
		end
	endtask

	task automatic drive_sample(input cplx_t d, input logic sop, input log2_pts_t size);
		@(posedge clk);
		in_valid <= 1'b1;
		in_sop   <= sop;
		in_size  <= size;
		in_data  <= d;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		in_valid <= 1'b0;
		in_sop   <= 1'b0;
	endtask

	// One frame of n samples on back-to-back cycles
	task automatic collect_frame(input int n);
		@(negedge clk);
		while (!out_valid)
			@(negedge clk);
		for (int k = 0; k < n; k++) begin
			if (out_valid !== 1'b1)
				report_mismatch($sformatf("out_valid[%0d]", k), 1, int'(out_valid));
			if (out_sop !== (k == 0))
				report_mismatch($sformatf("out_sop[%0d]", k), int'(k == 0), int'(out_sop));
			if (out_eop !== (k == n - 1))
				report_mismatch($sformatf("out_eop[%0d]", k), int'(k == n - 1), int'(out_eop));
			if (int'(out_data.re) != exp_re[k])
				report_mismatch($sformatf("out_data.re[%0d]", k), exp_re[k], int'(out_data.re));
			if (int'(out_data.im) != exp_im[k])
				report_mismatch($sformatf("out_data.im[%0d]", k), exp_im[k], int'(out_data.im));
			@(negedge clk);
		end
		// Frame must end right after the last point
		if (out_valid !== 1'b0)
			report_mismatch("out_valid after eop", 0, int'(out_valid));
	endtask

	task automatic run_packet(input test_entry_t t);
		int    n;
		int    set;
		int    frames_before;
		cplx_t junk;
		n       = (t.size == 2'd1) ? 2 : 4;
		set     = int'(t.idx);
		junk.re = 16'sh1234;
		junk.im = 16'sh4321;
		@(negedge clk);
		while (!sink_ready)
			@(negedge clk);
		if (t.tmo) begin
			// Only point 0 and then silence past the sink timeout
			frames_before = frames_seen;
			drive_sample(pool[set*4], 1'b1, t.size);
			pkt_started = 1'b1;
			drive_idle();
			repeat (`DFT_SINK_TIMEOUT + 4) @(negedge clk);
			if (frames_seen != frames_before) begin
				$display("Aborted packet at %0t still produced an output frame", $time);
				err_other++;
			end
			if (!sink_ready) begin
				$display("sink_ready still low at %0t after the sink timeout", $time);
				err_other++;
			end
		end else begin
			compute_expected(set, n);
			for (int m = 0; m < n; m++) begin
				// Gaps of 3 idle cycles stay well under the timeout
				if (t.gap && m > 0)
					repeat (3) drive_idle();
				drive_sample(pool[set*4+m], m == 0, t.size);
				pkt_started = 1'b1;
			end
			// Second sop while busy is dropped
			drive_sample(junk, 1'b1, t.size);
			@(negedge clk);
			if (sink_ready) begin
				$display("sink_ready high at %0t while a packet is being processed", $time);
				err_other++;
			end
			drive_idle();
			accepted++;
			collect_frame(n);
		end
	endtask

	// ------------------------------------------------------------------
	// Output monitor
	// ------------------------------------------------------------------
	always @(negedge clk) begin
		if (rst_n && out_sop)
			frames_seen++;
		if (rst_n && (out_valid || out_sop || out_eop) && !pkt_started) begin
			$display("Output strobe high at %0t before any packet was sent", $time);
			err_other++;
		end
	end

	// Run limit from the test lengths
	initial begin
		@(posedge clk);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Run stopped at %0t, no finish within %0d cycles", $time, cycle_limit);
		$display(">>> FAIL");
		$finish;
	end

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		in_valid    = 1'b0;
		in_sop      = 1'b0;
		in_size     = 2'd2;
		in_data     = '0;
		rst_n       = 1'b0;
		err_value   = 0;
		err_other   = 0;
		frames_seen = 0;
		accepted    = 0;
		cycle_cnt   = 0;
		pkt_started = 1'b0;
		lcg_state   = 32'd1;
		for (int i = 0; i < NUM_SETS * 4; i++) begin
			lcg_state   = lcg_next(lcg_state);
			pool[i].re  = lcg_sample(lcg_state);
			lcg_state   = lcg_next(lcg_state);
			pool[i].im  = lcg_sample(lcg_state);
		end
		// size, gap, timeout, sample set
		tests[0] = '{2'd1, 1'b0, 1'b0, 3'd0};
		tests[1] = '{2'd2, 1'b0, 1'b0, 3'd1};
		tests[2] = '{2'd2, 1'b1, 1'b0, 3'd1};
		tests[3] = '{2'd1, 1'b1, 1'b0, 3'd0};
		tests[4] = '{2'd2, 1'b0, 1'b1, 3'd2};
		tests[5] = '{2'd2, 1'b0, 1'b0, 3'd3};
		tests[6] = '{2'd1, 1'b0, 1'b1, 3'd4};
		// Illegal size runs as 4 points
		tests[7] = '{2'd3, 1'b0, 1'b0, 3'd5};
		cycle_limit = 0;
		for (int i = 0; i < NUM_TESTS; i++)
			cycle_limit += 40 + 4 * ((tests[i].size == 2'd1) ? 2 : 4);

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (state !== IDLE)
			report_mismatch("state", int'(IDLE), int'(state));
		if (sink_ready !== 1'b1)
			report_mismatch("sink_ready", 1, int'(sink_ready));
		if (out_valid !== 1'b0)
			report_mismatch("out_valid", 0, int'(out_valid));
		if (out_sop !== 1'b0)
			report_mismatch("out_sop", 0, int'(out_sop));
		if (out_eop !== 1'b0)
			report_mismatch("out_eop", 0, int'(out_eop));

		for (int i = 0; i < NUM_TESTS; i++)
			run_packet(tests[i]);

		repeat (4) @(negedge clk);
		if (frames_seen != accepted) begin
			$display("Saw %0d output frames for %0d accepted packets", frames_seen, accepted);
			err_other++;
		end
		$display("Done: %0d value errors, %0d other errors, %0d frames",
		         err_value, err_other, frames_seen);
		if (err_value + err_other == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/dft_mem_top.sv
// In-place DFT memory controller, 2- or 4-point radix-2 packets
// sink_ready is a level, high only while idle; output cannot be stalled

`default_nettype none
`timescale 1ns/1ps

module dft_mem_top
	import dft_types_pkg::*;
	import dft_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  logic       in_sop,
	input  log2_pts_t  in_size,
	input  cplx_t      in_data,
	output logic       sink_ready,
	output mem_state_t state,
	output logic       out_valid,
	output logic       out_sop,
	output logic       out_eop,
	output cplx_t      out_data
);

	// RAM ports
	addr_t     rd_addr_a;
	addr_t     rd_addr_b;
	cplx_t     rd_a;
	cplx_t     rd_b;
	logic      we_a;
	logic      we_b;
	addr_t     wr_addr_a;
	addr_t     wr_addr_b;
	cplx_t     wr_data_a;
	cplx_t     wr_data_b;
	// Butterfly traffic
	bfly_req_t bfly_req;
	logic      bfly_req_valid;
	bfly_res_t bfly_res;
	logic      bfly_res_valid;
	// Pass control
	log2_pts_t num_pts_log;
	logic      sink_done;
	logic      sink_abort;
	logic      wr_end;
	logic      src_rd_valid;
	logic      src_first;
	logic      src_last;

	dft_sequencer i_sequencer (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_sop         (in_sop),
		.in_size        (in_size),
		.sink_done      (sink_done),
		.sink_abort     (sink_abort),
		.wr_end         (wr_end),
		.rd_a           (rd_a),
		.rd_b           (rd_b),
		.state          (state),
		.sink_ready     (sink_ready),
		.rd_addr_a      (rd_addr_a),
		.rd_addr_b      (rd_addr_b),
		.bfly_req       (bfly_req),
		.bfly_req_valid (bfly_req_valid),
		.src_rd_valid   (src_rd_valid),
		.src_first      (src_first),
		.src_last       (src_last),
		.num_pts_log    (num_pts_log)
	);

	dft_sample_ram i_ram (
		.clk       (clk),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_a      (rd_a),
		.rd_b      (rd_b),
		.we_a      (we_a),
		.we_b      (we_b),
		.wr_addr_a (wr_addr_a),
		.wr_addr_b (wr_addr_b),
		.wr_data_a (wr_data_a),
		.wr_data_b (wr_data_b)
	);

	dft_butterfly i_butterfly (
		.clk            (clk),
		.rst_n          (rst_n),
		.bfly_req       (bfly_req),
		.bfly_req_valid (bfly_req_valid),
		.bfly_res       (bfly_res),
		.bfly_res_valid (bfly_res_valid)
	);

	dft_writeback i_writeback (
		.clk            (clk),
		.rst_n          (rst_n),
		.state          (state),
		.num_pts_log    (num_pts_log),
		.in_valid       (in_valid),
		.in_sop         (in_sop),
		.in_data        (in_data),
		.bfly_res       (bfly_res),
		.bfly_res_valid (bfly_res_valid),
		.we_a           (we_a),
		.we_b           (we_b),
		.wr_addr_a      (wr_addr_a),
		.wr_addr_b      (wr_addr_b),
		.wr_data_a      (wr_data_a),
		.wr_data_b      (wr_data_b),
		.sink_done      (sink_done),
		.sink_abort     (sink_abort),
		.wr_end         (wr_end)
	);

	dft_source i_source (
		.clk          (clk),
		.rst_n        (rst_n),
		.src_rd_valid (src_rd_valid),
		.src_first    (src_first),
		.src_last     (src_last),
		.rd_a         (rd_a),
		.out_valid    (out_valid),
		.out_sop      (out_sop),
		.out_eop      (out_eop),
		.out_data     (out_data)
	);

endmodule

`default_nettype wire

//--- hw/dft_source.sv
// Result stage, output side: frames the read-out spectrum
// Strobes from the sequencer are delayed by the 1-cycle RAM read latency
// No back-pressure, a frame is N back-to-back valid cycles

`default_nettype none
`timescale 1ns/1ps

module dft_source
	import dft_types_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  src_rd_valid,
	input  logic  src_first,
	input  logic  src_last,
	input  cplx_t rd_a,
	output logic  out_valid,
	output logic  out_sop,
	output logic  out_eop,
	output cplx_t out_data
);

	logic rd_valid_d;
	logic first_d;
	logic last_d;

	// Strobes aligned with RAM data, then registered with it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid_d <= 1'b0;
			first_d    <= 1'b0;
			last_d     <= 1'b0;
			out_valid  <= 1'b0;
			out_sop    <= 1'b0;
			out_eop    <= 1'b0;
		end else begin
			rd_valid_d <= src_rd_valid;
			first_d    <= src_first;
			last_d     <= src_last;
			out_valid  <= rd_valid_d;
			out_sop    <= rd_valid_d && first_d;
			out_eop    <= rd_valid_d && last_d;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= rd_a;
	end

endmodule

`default_nettype wire

//--- hw/dft_writeback.sv
// Result stage, memory side: sink writes, timeout, butterfly write-back
// sink_done, sink_abort and wr_end are single-cycle combinational pulses
// A sop is only taken in IDLE; later samples need just in_valid

`default_nettype none
`timescale 1ns/1ps

`include "dft_defines.svh"

module dft_writeback
	import dft_types_pkg::*;
	import dft_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  mem_state_t state,
	input  log2_pts_t  num_pts_log,
	input  logic       in_valid,
	input  logic       in_sop,
	input  cplx_t      in_data,
	input  bfly_res_t  bfly_res,
	input  logic       bfly_res_valid,
	output logic       we_a,
	output logic       we_b,
	output addr_t      wr_addr_a,
	output addr_t      wr_addr_b,
	output cplx_t      wr_data_a,
	output cplx_t      wr_data_b,
	output logic       sink_done,
	output logic       sink_abort,
	output logic       wr_end
);

	logic       sink_mode;
	logic       accept;
	addr_t      sink_addr;
	addr_t      sink_cnt;
	addr_t      last_pt;
	logic       res_last;
	logic       res_cnt;
	logic [4:0] idle_cnt;

	assign sink_mode = (state == IDLE) || (state == SINK);
	// Point 0 comes with the sop in IDLE, the rest in SINK
	assign accept    = (state == IDLE) ? (in_valid && in_sop) : ((state == SINK) && in_valid);
	assign sink_addr = (state == IDLE) ? '0 : sink_cnt;
	assign last_pt   = (num_pts_log == 2'd1) ? 2'd1 : 2'd3;
	// N/2 results per pass
	assign res_last  = (num_pts_log != 2'd1);

	// ------------------------------------------------------------------
	// Pass control pulses
	// ------------------------------------------------------------------
	assign sink_done  = (state == SINK) && in_valid && (sink_cnt == last_pt);
	assign sink_abort = (state == SINK) && !in_valid &&
	                    (idle_cnt == 5'(`DFT_SINK_TIMEOUT - 1));
	assign wr_end     = !sink_mode && bfly_res_valid && (res_cnt == res_last);

	// Write port muxing, port B idle while sinking
	assign we_a      = sink_mode ? accept : bfly_res_valid;
	assign we_b      = !sink_mode && bfly_res_valid;
	assign wr_addr_a = sink_mode ? sink_addr : bfly_res.addr_a;
	assign wr_data_a = sink_mode ? in_data : bfly_res.sum;
	assign wr_addr_b = bfly_res.addr_b;
	assign wr_data_b = bfly_res.diff;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sink_cnt <= '0;
			idle_cnt <= '0;
			res_cnt  <= 1'b0;
		end else begin
			if (accept)
				sink_cnt <= sink_addr + 1'b1;
			// Consecutive idle cycles inside a packet
			if ((state == SINK) && !in_valid)
				idle_cnt <= idle_cnt + 1'b1;
			else
				idle_cnt <= '0;
			if (sink_mode)
				res_cnt <= 1'b0;
			else if (bfly_res_valid)
				res_cnt <= wr_end ? 1'b0 : ~res_cnt;
		end
	end

endmodule

`default_nettype wire

//--- hw/dft_butterfly.sv
// Execute stage: radix-2 butterfly, two register stages
// Sums and differences wrap at the sample width
// Fully pipelined, a new request may enter every cycle

`default_nettype none
`timescale 1ns/1ps

module dft_butterfly
	import dft_types_pkg::*;
	import dft_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  bfly_req_t bfly_req,
	input  logic      bfly_req_valid,
	output bfly_res_t bfly_res,
	output logic      bfly_res_valid
);

	// Multiply by -j: (re + j*im)(-j) = im - j*re
	function automatic cplx_t mul_neg_j(input cplx_t d);
		cplx_t r;
		r.re = d.im;
		r.im = -d.re;
		return r;
	endfunction

	cplx_t s1_sum;
	cplx_t s1_diff;
	addr_t s1_addr_a;
	addr_t s1_addr_b;
	logic  s1_rot;
	logic  s1_valid;

	// Valid pipe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid       <= 1'b0;
			bfly_res_valid <= 1'b0;
		end else begin
			s1_valid       <= bfly_req_valid;
			bfly_res_valid <= s1_valid;
		end
	end

	// Stage 1, add and subtract
	always_ff @(posedge clk) begin
		s1_sum.re  <= bfly_req.a.re + bfly_req.b.re;
		s1_sum.im  <= bfly_req.a.im + bfly_req.b.im;
		s1_diff.re <= bfly_req.a.re - bfly_req.b.re;
		s1_diff.im <= bfly_req.a.im - bfly_req.b.im;
		s1_addr_a  <= bfly_req.addr_a;
		s1_addr_b  <= bfly_req.addr_b;
		s1_rot     <= bfly_req.rot_j;
	end

	// Stage 2, twiddle on the difference where flagged
	always_ff @(posedge clk) begin
		bfly_res.sum    <= s1_sum;
		bfly_res.diff   <= s1_rot ? mul_neg_j(s1_diff) : s1_diff;
		bfly_res.addr_a <= s1_addr_a;
		bfly_res.addr_b <= s1_addr_b;
	end

endmodule

`default_nettype wire

//--- hw/dft_sequencer.sv
// Decode stage: controller FSM, stage and pair counters, read addresses
// Radix-2 DIF in place; N=4 needs two stages, N=2 one
// Read addresses are combinational, RAM data lines up one cycle later

`default_nettype none
`timescale 1ns/1ps

module dft_sequencer
	import dft_types_pkg::*;
	import dft_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  logic       in_sop,
	input  log2_pts_t  in_size,
	input  logic       sink_done,
	input  logic       sink_abort,
	input  logic       wr_end,
	input  cplx_t      rd_a,
	input  cplx_t      rd_b,
	output mem_state_t state,
	output logic       sink_ready,
	output addr_t      rd_addr_a,
	output addr_t      rd_addr_b,
	output bfly_req_t  bfly_req,
	output logic       bfly_req_valid,
	output logic       src_rd_valid,
	output logic       src_first,
	output logic       src_last,
	output log2_pts_t  num_pts_log
);

	logic  n4;
	logic  pair_cnt;
	logic  stage;
	addr_t src_cnt;
	logic  last_pair;
	logic  last_stage;
	logic  src_end;
	logic  rd_issue;
	logic  rot_j;
	addr_t pair_a;
	addr_t pair_b;
	// Held for one cycle to meet the RAM data
	logic  issue_d;
	addr_t addr_a_d;
	addr_t addr_b_d;
	logic  rot_j_d;

	assign n4         = (num_pts_log == 2'd2);
	assign last_pair  = !n4 || pair_cnt;
	assign last_stage = !n4 || stage;
	assign src_end    = (src_cnt == (n4 ? 2'd3 : 2'd1));
	assign sink_ready = (state == IDLE);
	assign rd_issue   = (state == RD);

	// ------------------------------------------------------------------
	// Address generation
	// ------------------------------------------------------------------
	// Stage 0 of N=4 pairs points two apart, otherwise neighbours
	always_comb begin
		if (n4 && !stage) begin
			pair_a = {1'b0, pair_cnt};
			pair_b = {1'b1, pair_cnt};
		end else begin
			pair_a = {pair_cnt, 1'b0};
			pair_b = {pair_cnt, 1'b1};
		end
	end

	// Only the (1,3) butterfly of the first N=4 stage sees W4^1 = -j
	assign rot_j = n4 && !stage && pair_cnt;

	// Source reads in bit-reversed order through port A
	assign rd_addr_a    = (state == SOURCE) ? (n4 ? {src_cnt[0], src_cnt[1]} : src_cnt) : pair_a;
	assign rd_addr_b    = pair_b;
	assign src_rd_valid = (state == SOURCE);
	assign src_first    = src_rd_valid && (src_cnt == 2'd0);
	assign src_last     = src_rd_valid && src_end;

	// ------------------------------------------------------------------
	// Controller FSM
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= IDLE;
			num_pts_log <= 2'd2;
			pair_cnt    <= 1'b0;
			stage       <= 1'b0;
			src_cnt     <= '0;
		end else begin
			case (state)
			IDLE: begin
				// Size captured with the accepted sop, illegal sizes run as N=4
				if (in_valid && in_sop) begin
					state       <= SINK;
					num_pts_log <= (in_size == 2'd1) ? 2'd1 : 2'd2;
				end
			end
			SINK: begin
				if (sink_abort) begin
					state <= IDLE;
				end else if (sink_done) begin
					state    <= RD;
					stage    <= 1'b0;
					pair_cnt <= 1'b0;
				end
			end
			RD: begin
				// One pair per cycle
				if (last_pair) begin
					state    <= WAIT_WR;
					pair_cnt <= 1'b0;
				end else begin
					pair_cnt <= pair_cnt + 1'b1;
				end
			end
			WAIT_WR: begin
				if (wr_end) begin
					if (last_stage) begin
						state   <= SOURCE;
						src_cnt <= '0;
					end else begin
						state <= RD;
						stage <= 1'b1;
					end
				end
			end
			SOURCE: begin
				if (src_end)
					state <= IDLE;
				else
					src_cnt <= src_cnt + 1'b1;
			end
			default: state <= IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Butterfly request
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_d        <= 1'b0;
			bfly_req_valid <= 1'b0;
		end else begin
			issue_d        <= rd_issue;
			bfly_req_valid <= issue_d;
		end
	end

	// Operands straight from RAM, addresses and flag from the issue cycle
	always_ff @(posedge clk) begin
		addr_a_d        <= pair_a;
		addr_b_d        <= pair_b;
		rot_j_d         <= rot_j;
		bfly_req.a      <= rd_a;
		bfly_req.b      <= rd_b;
		bfly_req.addr_a <= addr_a_d;
		bfly_req.addr_b <= addr_b_d;
		bfly_req.rot_j  <= rot_j_d;
	end

endmodule

`default_nettype wire

//--- hw/dft_sample_ram.sv
// Four-word complex sample store, two read and two write ports
// Reads are registered, one cycle latency, old data on a same-cycle write
// The two write ports must never hit the same address together

`default_nettype none
`timescale 1ns/1ps

`include "dft_defines.svh"

module dft_sample_ram
	import dft_types_pkg::*;
(
	input  logic  clk,
	input  addr_t rd_addr_a,
	input  addr_t rd_addr_b,
	output cplx_t rd_a,
	output cplx_t rd_b,
	input  logic  we_a,
	input  logic  we_b,
	input  addr_t wr_addr_a,
	input  addr_t wr_addr_b,
	input  cplx_t wr_data_a,
	input  cplx_t wr_data_b
);

	cplx_t mem [`DFT_MAX_PTS];

	// Synchronous read ports
	always_ff @(posedge clk) begin
		rd_a <= mem[rd_addr_a];
		rd_b <= mem[rd_addr_b];
	end

	// Write ports, A carries sink samples and sums, B carries differences
	always_ff @(posedge clk) begin
		if (we_a)
			mem[wr_addr_a] <= wr_data_a;
		if (we_b)
			mem[wr_addr_b] <= wr_data_b;
	end

endmodule

`default_nettype wire

//--- hw/dft_ctrl_pkg.sv
// Control types for the sequencer, butterfly and write-back
// State encoding is visible at the top level, keep it stable

`default_nettype none

package dft_ctrl_pkg;

	import dft_types_pkg::*;

	// Controller states
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		SINK    = 3'd1,
		RD      = 3'd2,
		WAIT_WR = 3'd3,
		SOURCE  = 3'd4
	} mem_state_t;

	// Butterfly operands plus where the results go back
	// Valid travels on its own wire
	typedef struct packed {
		cplx_t a;
		cplx_t b;
		addr_t addr_a;
		addr_t addr_b;
		logic  rot_j;
	} bfly_req_t;

	// Butterfly outputs, sum goes to addr_a and diff to addr_b
	typedef struct packed {
		cplx_t sum;
		cplx_t diff;
		addr_t addr_a;
		addr_t addr_b;
	} bfly_res_t;

endpackage

`default_nettype wire

//--- hw/dft_types_pkg.sv
// Data types shared by the datapath
// Arithmetic on sample_t wraps at DFT_DATA_W bits, no scaling anywhere

`default_nettype none

`include "dft_defines.svh"

package dft_types_pkg;

	// One real or imaginary part, two's complement
	typedef logic signed [`DFT_DATA_W-1:0] sample_t;

	// Complex sample, real part in the upper half
	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// Sample memory address
	typedef logic [`DFT_ADDR_W-1:0] addr_t;

	// log2 of the point count; 1 means 2 points, anything else 4 points
	typedef logic [1:0] log2_pts_t;

endpackage

`default_nettype wire

//--- include/dft_defines.svh
// Sizing for the reduced DFT memory controller
// Only 2- and 4-point packets are supported, so the memory stays at four words
// DFT_ADDR_W must cover DFT_MAX_PTS entries

`ifndef DFT_DEFINES_SVH
`define DFT_DEFINES_SVH

// Width of one real or imaginary part
`define DFT_DATA_W 16

// Largest packet, in complex points
`define DFT_MAX_PTS 4

// Sample memory address width
`define DFT_ADDR_W 2

// Idle cycles inside a packet before it is dropped
`define DFT_SINK_TIMEOUT 16

`endif
